/* Bender.yml */
package:
  name: cache

sources:
  - files:
      - source/cache_pkg.sv
      - source/cache_controller.sv
      - source/cache_datapath.sv
      - source/cache_top.sv
  - target: test
    files:
      - verification/mem_model.sv
      - verification/cache_tb.sv

/* compile.f */
source/cache_pkg.sv
source/cache_controller.sv
source/cache_datapath.sv
source/cache_top.sv
verification/mem_model.sv
verification/cache_tb.sv

/* source/cache_controller.sv */
module cache_controller (
    input  logic            clk,
    input  logic            rst,
    input  logic            src_valid,
    input  logic            cpu_request,
    input  logic            flush_req,
    input  logic            req_type,
    input  logic            cache_hit,
    input  logic            dirty,
    input  logic            axi_ack,
    input  logic            flush,
    input  logic            flush_done,
    output logic            src_ready,
    output logic            resp_valid,
    output logic            rd_en,
    output logic            wr_en,
    output logic            mem_rd_req,
    output logic            mem_wr_req,
    output logic            data_sel,
    output logic            index_sel,
    output logic            count_en,
    output logic            count_clear,
    output logic            reg_flush_en,
    output logic            valid_clear,
    output cache_pkg::sel_t dirty_sel,
    output cache_pkg::sel_t valid_sel
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        PROCESS_REQ,
        CACHE_ALLOCATE,
        WRITEBACK,
        FLUSH_STATE
    } cache_state_t;

    cache_state_t c_state;
    cache_state_t n_state;
    logic         access_go;
    logic         flush_go;

    // an access wins over a flush offered in the same cycle
    assign access_go = src_valid & cpu_request & ~flush;
    assign flush_go  = src_valid & flush_req & ~access_go;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            c_state <= IDLE;
        else
            c_state <= n_state;
    end

    always_comb
    begin
        n_state = c_state;
        case (c_state)
            IDLE:
            begin
                if (access_go)
                    n_state = PROCESS_REQ;
                else if (flush_go)
                    n_state = FLUSH_STATE;
            end
            PROCESS_REQ:
            begin
                if (!cache_hit && dirty)
                    n_state = WRITEBACK;
                else if (!cache_hit)
                    n_state = CACHE_ALLOCATE;
                else
                    n_state = IDLE;
            end
            CACHE_ALLOCATE:
            begin
                // the filled line is looked up again and now hits
                if (axi_ack)
                    n_state = PROCESS_REQ;
            end
            WRITEBACK:
            begin
                if (axi_ack && flush)
                    n_state = FLUSH_STATE;
                else if (axi_ack)
                    n_state = CACHE_ALLOCATE;
            end
            FLUSH_STATE:
            begin
                if (flush_done)
                    n_state = IDLE;
                else if (dirty)
                    n_state = WRITEBACK;
            end
            default:
                n_state = IDLE;
        endcase
    end

    always_comb
    begin
        src_ready    = 1'b0;
        resp_valid   = 1'b0;
        rd_en        = 1'b0;
        wr_en        = 1'b0;
        mem_rd_req   = 1'b0;
        mem_wr_req   = 1'b0;
        data_sel     = 1'b0;
        index_sel    = 1'b0;
        count_en     = 1'b0;
        count_clear  = 1'b0;
        reg_flush_en = 1'b0;
        valid_clear  = 1'b0;
        dirty_sel    = SEL_HOLD;
        valid_sel    = SEL_HOLD;
        case (c_state)
            IDLE:
            begin
                src_ready = 1'b1;
                // flush start: rewind counter, raise flag, drop every line
                if (flush_go)
                begin
                    count_clear  = 1'b1;
                    index_sel    = 1'b1;
                    reg_flush_en = 1'b1;
                    valid_clear  = 1'b1;
                end
            end
            PROCESS_REQ:
            begin
                if (cache_hit)
                begin
                    resp_valid = 1'b1;
                    if (req_type)
                    begin
                        wr_en     = 1'b1;
                        dirty_sel = SEL_SET;
                        valid_sel = SEL_SET;
                    end
                    else
                        rd_en = 1'b1;
                end
                else if (dirty)
                begin
                    // victim goes out first, read it for the write data
                    mem_wr_req = 1'b1;
                    rd_en      = 1'b1;
                end
                else
                    mem_rd_req = 1'b1;
            end
            CACHE_ALLOCATE:
            begin
                if (axi_ack)
                begin
                    valid_sel = SEL_SET;
                    data_sel  = 1'b1;
                    wr_en     = 1'b1;
                end
                else
                    mem_rd_req = 1'b1;
            end
            WRITEBACK:
            begin
                // a flush writes back the line under the flush counter
                index_sel = flush;
                if (axi_ack && flush)
                    dirty_sel = SEL_CLEAR;
                else if (axi_ack)
                    mem_rd_req = 1'b1;
                else
                begin
                    mem_wr_req = 1'b1;
                    rd_en      = 1'b1;
                end
            end
            FLUSH_STATE:
            begin
                if (flush_done)
                    reg_flush_en = 1'b1;
                else if (dirty)
                begin
                    mem_wr_req = 1'b1;
                    rd_en      = 1'b1;
                    index_sel  = 1'b1;
                end
                else
                begin
                    count_en  = 1'b1;
                    index_sel = 1'b1;
                end
            end
            default:
            begin
                src_ready = 1'b0;
            end
        endcase
    end

    mem_req_exclusive: assert property (
        @(posedge clk) disable iff (!rst) !(mem_rd_req && mem_wr_req)
    ) else $error("memory read and write requested together");

    ready_only_idle: assert property (
        @(posedge clk) disable iff (!rst) src_ready |-> (c_state == IDLE)
    ) else $error("src_ready raised outside IDLE");

endmodule

/* source/cache_datapath.sv */
module cache_datapath #(
    parameter int ADDR_WIDTH  = cache_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH  = cache_pkg::DATA_WIDTH,
    parameter int INDEX_WIDTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             src_valid,
    input  logic             src_ready,
    input  logic             cpu_request,
    input  logic             req_type_in,
    input  cache_pkg::addr_t cpu_addr,
    input  cache_pkg::word_t cpu_wdata,
    input  logic             rd_en,
    input  logic             wr_en,
    input  logic             data_sel,
    input  cache_pkg::sel_t  dirty_sel,
    input  cache_pkg::sel_t  valid_sel,
    input  logic             index_sel,
    input  logic             count_en,
    input  logic             count_clear,
    input  logic             reg_flush_en,
    input  logic             valid_clear,
    input  cache_pkg::word_t mem_rdata,
    output logic             req_type,
    output logic             cache_hit,
    output logic             dirty,
    output logic             flush,
    output logic             flush_done,
    output cache_pkg::word_t cpu_rdata,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::word_t mem_wdata,
    output logic             flush_busy
);
    import cache_pkg::*;

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH;
    localparam int LINES     = 2 ** INDEX_WIDTH;

    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;

    if (ADDR_WIDTH != $bits(addr_t) || DATA_WIDTH != $bits(word_t) ||
        INDEX_WIDTH >= ADDR_WIDTH)
    begin : g_width_check
        $error("cache_datapath widths do not match the cache_pkg types");
    end

    tag_t                  tag_array  [LINES];
    logic [DATA_WIDTH-1:0] data_array [LINES];
    logic [LINES-1:0]      valid_bits;
    logic [LINES-1:0]      dirty_bits;

    addr_t  req_addr;
    word_t  req_wdata;
    tag_t   req_tag;
    index_t req_index;
    index_t flush_index;
    index_t line_index;
    logic   flush_flag;
    logic   accept;

    assign accept     = src_valid & cpu_request & src_ready;
    assign req_tag    = req_addr[ADDR_WIDTH-1:INDEX_WIDTH];
    assign req_index  = req_addr[INDEX_WIDTH-1:0];
    assign line_index = index_sel ? flush_index : req_index;

    // held for the whole access, the requester may move on
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_type  <= req_type_in;
            req_addr  <= cpu_addr;
            req_wdata <= cpu_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            flush_index <= '0;
            flush_flag  <= 1'b0;
        end
        else
        begin
            if (count_clear)
                flush_index <= '0;
            else if (count_en)
                flush_index <= flush_index + index_t'(1);
            // set on flush start, cleared on the last clean line
            if (reg_flush_en)
                flush_flag <= ~flush_flag;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end
        else
        begin
            if (valid_clear)
                valid_bits <= '0;
            else if (valid_sel == SEL_SET)
                valid_bits[line_index] <= 1'b1;
            // a fresh fill is always clean
            if (wr_en && data_sel)
                dirty_bits[line_index] <= 1'b0;
            else if (dirty_sel == SEL_SET)
                dirty_bits[line_index] <= 1'b1;
            else if (dirty_sel == SEL_CLEAR)
                dirty_bits[line_index] <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            if (data_sel)
            begin
                data_array[line_index] <= mem_rdata;
                tag_array[line_index]  <= req_tag;
            end
            else
                data_array[line_index] <= req_wdata;
        end
    end

    assign cache_hit  = valid_bits[line_index] && (tag_array[line_index] == req_tag);
    assign dirty      = dirty_bits[line_index];
    assign flush_done = (flush_index == index_t'(LINES - 1)) && !dirty_bits[flush_index];
    assign flush      = flush_flag;
    assign flush_busy = flush_flag;

    assign cpu_rdata = rd_en ? data_array[line_index] : '0;
    assign mem_wdata = data_array[line_index];
    // writeback goes to the stored tag, a fill to the requested address
    assign mem_addr  = rd_en ? {tag_array[line_index], line_index} : req_addr;

    count_only_in_flush: assert property (
        @(posedge clk) disable iff (!rst) count_en |-> flush_flag
    ) else $error("flush counter advanced with no flush running");

endmodule

/* source/cache_pkg.sv */
package cache_pkg;

    // word addressed, so one address is one data word
    localparam int ADDR_WIDTH = 12;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] word_t;

    // update code for the per line valid and dirty bits
    typedef logic [1:0] sel_t;

    localparam sel_t SEL_HOLD  = 2'd0;
    // only the dirty bits take a clear code
    localparam sel_t SEL_CLEAR = 2'd1;
    localparam sel_t SEL_SET   = 2'd2;

endpackage

/* source/cache_top.sv */
module cache_top #(
    parameter int ADDR_WIDTH  = cache_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH  = cache_pkg::DATA_WIDTH,
    parameter int INDEX_WIDTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             src_valid,
    input  logic             cpu_request,
    input  logic             req_type,
    input  cache_pkg::addr_t cpu_addr,
    input  cache_pkg::word_t cpu_wdata,
    input  logic             flush_req,
    output logic             src_ready,
    output logic             resp_valid,
    output cache_pkg::word_t cpu_rdata,
    output logic             flush_busy,
    output logic             mem_rd_req,
    output logic             mem_wr_req,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::word_t mem_wdata,
    input  cache_pkg::word_t mem_rdata,
    input  logic             mem_ack
);
    import cache_pkg::*;

    logic rd_en;
    logic wr_en;
    logic data_sel;
    logic index_sel;
    logic count_en;
    logic count_clear;
    logic reg_flush_en;
    logic valid_clear;
    sel_t dirty_sel;
    sel_t valid_sel;

    // captured request kind and line status back to the FSM
    logic req_type_r;
    logic cache_hit;
    logic dirty;
    logic flush;
    logic flush_done;

    cache_controller u_controller (
        .clk          (clk),
        .rst          (rst),
        .src_valid    (src_valid),
        .cpu_request  (cpu_request),
        .flush_req    (flush_req),
        .req_type     (req_type_r),
        .cache_hit    (cache_hit),
        .dirty        (dirty),
        .axi_ack      (mem_ack),
        .flush        (flush),
        .flush_done   (flush_done),
        .src_ready    (src_ready),
        .resp_valid   (resp_valid),
        .rd_en        (rd_en),
        .wr_en        (wr_en),
        .mem_rd_req   (mem_rd_req),
        .mem_wr_req   (mem_wr_req),
        .data_sel     (data_sel),
        .index_sel    (index_sel),
        .count_en     (count_en),
        .count_clear  (count_clear),
        .reg_flush_en (reg_flush_en),
        .valid_clear  (valid_clear),
        .dirty_sel    (dirty_sel),
        .valid_sel    (valid_sel)
    );

    cache_datapath #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .DATA_WIDTH  (DATA_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_datapath (
        .clk          (clk),
        .rst          (rst),
        .src_valid    (src_valid),
        .src_ready    (src_ready),
        .cpu_request  (cpu_request),
        .req_type_in  (req_type),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .rd_en        (rd_en),
        .wr_en        (wr_en),
        .data_sel     (data_sel),
        .dirty_sel    (dirty_sel),
        .valid_sel    (valid_sel),
        .index_sel    (index_sel),
        .count_en     (count_en),
        .count_clear  (count_clear),
        .reg_flush_en (reg_flush_en),
        .valid_clear  (valid_clear),
        .mem_rdata    (mem_rdata),
        .req_type     (req_type_r),
        .cache_hit    (cache_hit),
        .dirty        (dirty),
        .flush        (flush),
        .flush_done   (flush_done),
        .cpu_rdata    (cpu_rdata),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .flush_busy   (flush_busy)
    );

endmodule

/* verification/cache_tb.sv */
module cache_tb;
    import cache_pkg::*;

    localparam int    INDEX_WIDTH = 4;
    localparam int    LINES       = 2 ** INDEX_WIDTH;
    localparam int    TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH;
    localparam word_t MEM_PATTERN = 32'h3c5a_0000;
    localparam int    N_READS     = 24;
    localparam int    N_WRITES    = 12;
    localparam int    N_REREADS   = 8;
    // random reads, four hit accesses, two for eviction, writes, rereads
    localparam int    N_ACCESSES  = N_READS + 4 + 2 + N_WRITES + N_REREADS;
    localparam int    CYCLE_LIMIT = 8 + 40 * N_ACCESSES + 20 * LINES;

    logic  clk;
    logic  rst;
    logic  src_valid;
    logic  cpu_request;
    logic  req_type;
    addr_t cpu_addr;
    word_t cpu_wdata;
    logic  flush_req;
    logic  src_ready;
    logic  resp_valid;
    word_t cpu_rdata;
    logic  flush_busy;
    logic  mem_rd_req;
    logic  mem_wr_req;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_ack;

    // reference: last value written per address, and the expected line state
    word_t                ref_mem [2 ** ADDR_WIDTH];
    logic [LINES-1:0]     line_valid;
    logic [LINES-1:0]     line_dirty;
    logic [TAG_WIDTH-1:0] line_tag [LINES];
    addr_t                written [$];

    word_t       exp_rdata;
    addr_t       wb_addr;
    logic        cur_write;
    logic        expect_hit;
    logic        expect_miss;
    logic        expect_wb;
    logic        in_flight;
    logic        reset_chk;
    int          rd_cycles = 0;
    int          wr_cycles = 0;
    int          rd_start;
    int          wr_start;
    int          cycles = 0;
    int          errors = 0;
    int          test_start;
    int          tests_run = 0;
    int          failed_tests = 0;
    string       test_name = "setup";
    logic [15:0] lfsr = 16'd17;

    cache_top #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .DATA_WIDTH  (DATA_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .src_valid   (src_valid),
        .cpu_request (cpu_request),
        .req_type    (req_type),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .flush_req   (flush_req),
        .src_ready   (src_ready),
        .resp_valid  (resp_valid),
        .cpu_rdata   (cpu_rdata),
        .flush_busy  (flush_busy),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_ack     (mem_ack)
    );

    mem_model #(
        .LATENCY (3),
        .PATTERN (MEM_PATTERN)
    ) u_mem (
        .clk        (clk),
        .rst        (rst),
        .mem_rd_req (mem_rd_req),
        .mem_wr_req (mem_wr_req),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // memory request cycles, tells a hit from a miss
    always @(posedge clk)
    begin
        if (mem_rd_req)
            rd_cycles <= rd_cycles + 1;
        if (mem_wr_req)
            wr_cycles <= wr_cycles + 1;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles in test %s", cycles, test_name);
            $display("Errors found");
            $finish;
        end
    end

    reset_outputs: assert property (@(posedge clk)
        reset_chk |-> src_ready && !resp_valid && !mem_rd_req && !mem_wr_req && !flush_busy)
    else
    begin
        errors++;
        $display("outputs are not in their idle state after reset");
    end

    read_value: assert property (@(posedge clk) disable iff (!rst)
        resp_valid && !cur_write |-> cpu_rdata == exp_rdata)
    else
    begin
        errors++;
        $display("error %s: expected %h, actual %h", test_name, exp_rdata, $sampled(cpu_rdata));
    end

    hit_no_memory: assert property (@(posedge clk) disable iff (!rst)
        expect_hit |-> !mem_rd_req && !mem_wr_req)
    else
    begin
        errors++;
        $display("memory request issued for an access that should hit in %s", test_name);
    end

    miss_reads_memory: assert property (@(posedge clk) disable iff (!rst)
        resp_valid && expect_miss |-> rd_cycles != rd_start)
    else
    begin
        errors++;
        $display("miss completed without a memory read in %s", test_name);
    end

    eviction_writes: assert property (@(posedge clk) disable iff (!rst)
        resp_valid && expect_wb |-> wr_cycles != wr_start)
    else
    begin
        errors++;
        $display("dirty line replaced without a memory write in %s", test_name);
    end

    eviction_addr: assert property (@(posedge clk) disable iff (!rst)
        mem_wr_req && expect_wb |-> mem_addr == wb_addr)
    else
    begin
        errors++;
        $display("error %s: expected %h, actual %h", test_name, wb_addr, $sampled(mem_addr));
    end

    // a dirty line always holds the latest value of its address
    writeback_data: assert property (@(posedge clk) disable iff (!rst)
        mem_wr_req |-> mem_wdata == ref_mem[mem_addr])
    else
    begin
        errors++;
        $display("error %s: expected %h, actual %h", test_name,
                 ref_mem[$sampled(mem_addr)], $sampled(mem_wdata));
    end

    busy_not_ready: assert property (@(posedge clk) disable iff (!rst)
        in_flight || flush_busy |-> !src_ready)
    else
    begin
        errors++;
        $display("src_ready high while a request is still running in %s", test_name);
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != test_start)
            failed_tests++;
        $display("test %s done, %0d check failures", test_name, errors - test_start);
    endtask

    task automatic check_shadow(input addr_t addr);
        assert (u_mem.store[addr] == ref_mem[addr])
        else
        begin
            errors++;
            $display("error %s: expected %h, actual %h", test_name, ref_mem[addr],
                     u_mem.store[addr]);
        end
    endtask

    task automatic run_access(input logic write, input addr_t addr, input word_t data);
        logic [INDEX_WIDTH-1:0] idx;
        logic [TAG_WIDTH-1:0]   tag;
        logic                   was_hit;
        idx         = addr[INDEX_WIDTH-1:0];
        tag         = addr[ADDR_WIDTH-1:INDEX_WIDTH];
        was_hit     = line_valid[idx] && (line_tag[idx] == tag);
        expect_hit  = was_hit;
        expect_miss = !was_hit;
        expect_wb   = !was_hit && line_dirty[idx];
        wb_addr     = {line_tag[idx], idx};
        rd_start    = rd_cycles;
        wr_start    = wr_cycles;
        cur_write   = write;
        if (write)
        begin
            ref_mem[addr] = data;
            written.push_back(addr);
        end
        exp_rdata   = ref_mem[addr];
        src_valid   = 1'b1;
        cpu_request = 1'b1;
        req_type    = write;
        cpu_addr    = addr;
        cpu_wdata   = data;
        @(posedge clk);
        while (!src_ready)
            @(posedge clk);
        #1;
        src_valid   = 1'b0;
        cpu_request = 1'b0;
        in_flight   = 1'b1;
        do
            @(posedge clk);
        while (!resp_valid);
        #1;
        in_flight   = 1'b0;
        expect_hit  = 1'b0;
        expect_miss = 1'b0;
        expect_wb   = 1'b0;
        // line now holds this address, dirty after any write
        line_valid[idx] = 1'b1;
        line_tag[idx]   = tag;
        line_dirty[idx] = write || (was_hit && line_dirty[idx]);
    endtask

    task automatic run_flush();
        src_valid = 1'b1;
        flush_req = 1'b1;
        @(posedge clk);
        while (!src_ready)
            @(posedge clk);
        #1;
        src_valid = 1'b0;
        flush_req = 1'b0;
        do
            @(posedge clk);
        while (flush_busy);
        #1;
        line_valid = '0;
        line_dirty = '0;
    endtask

    initial
    begin
        addr_t       a;
        logic [31:0] bits;
        rst         = 1'b0;
        src_valid   = 1'b0;
        cpu_request = 1'b0;
        req_type    = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        flush_req   = 1'b0;
        cur_write   = 1'b0;
        expect_hit  = 1'b0;
        expect_miss = 1'b0;
        expect_wb   = 1'b0;
        in_flight   = 1'b0;
        reset_chk   = 1'b0;
        exp_rdata   = '0;
        wb_addr     = '0;
        line_valid  = '0;
        line_dirty  = '0;
        // memory starts at address xor a constant
        for (int i = 0; i < 2 ** ADDR_WIDTH; i++)
            ref_mem[i] = word_t'(i) ^ MEM_PATTERN;
        repeat (8)
            @(posedge clk);
        #1;
        rst = 1'b1;

        start_test("reset");
        reset_chk = 1'b1;
        @(posedge clk);
        #1;
        reset_chk = 1'b0;
        finish_test();

        start_test("reads");
        repeat (N_READS)
        begin
            random_bits(ADDR_WIDTH, bits);
            run_access(1'b0, addr_t'(bits), '0);
        end
        finish_test();

        start_test("hits");
        random_bits(ADDR_WIDTH, bits);
        a = addr_t'(bits);
        random_bits(DATA_WIDTH, bits);
        run_access(1'b0, a, '0);
        run_access(1'b0, a, '0);
        run_access(1'b1, a, bits);
        run_access(1'b0, a, '0);
        finish_test();

        start_test("eviction");
        random_bits(DATA_WIDTH, bits);
        run_access(1'b1, a, bits);
        // same index, other tag
        run_access(1'b0, a ^ addr_t'(LINES), '0);
        check_shadow(a);
        repeat (N_WRITES)
        begin
            random_bits(ADDR_WIDTH, bits);
            a = addr_t'(bits);
            random_bits(DATA_WIDTH, bits);
            run_access(1'b1, a, bits);
        end
        finish_test();

        start_test("flush");
        run_flush();
        foreach (written[i])
            check_shadow(written[i]);
        for (int i = 0; i < N_REREADS; i++)
            run_access(1'b0, written[i], '0);
        finish_test();

        $display("tests run %0d, failed %0d, check failures %0d",
                 tests_run, failed_tests, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* verification/mem_model.sv */
module mem_model #(
    parameter int               LATENCY = 3,
    parameter cache_pkg::word_t PATTERN = 32'h5a5a_0000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             mem_rd_req,
    input  logic             mem_wr_req,
    input  cache_pkg::addr_t mem_addr,
    input  cache_pkg::word_t mem_wdata,
    output cache_pkg::word_t mem_rdata,
    output logic             mem_ack
);
    import cache_pkg::*;

    localparam int WORDS = 2 ** $bits(addr_t);

    // memory contents, also read back as the shadow of written data
    word_t store [WORDS];
    int    wait_count;

    always @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            mem_ack    <= 1'b0;
            mem_rdata  <= '0;
            wait_count <= 0;
            for (int a = 0; a < WORDS; a++)
                store[a] <= word_t'(a) ^ PATTERN;
        end
        else
        begin
            mem_ack <= 1'b0;
            // request level drops in the ack cycle, start over after it
            if (mem_ack)
                wait_count <= 0;
            else if (mem_rd_req || mem_wr_req)
            begin
                if (wait_count == LATENCY - 1)
                begin
                    mem_ack <= 1'b1;
                    if (mem_wr_req)
                        store[mem_addr] <= mem_wdata;
                    else
                        mem_rdata <= store[mem_addr];
                end
                wait_count <= wait_count + 1;
            end
        end
    end

endmodule
